//--- common/soc_pkg.sv
// SoC peripheral definitions
`default_nettype none

package soc_pkg;

	// Bus and word widths
	localparam int ARCH_W = 32;
	localparam int ADDR_W = ARCH_W - 2;
	localparam int SEL_W = ARCH_W / 8;

	// Each device window is 16 words
	localparam int WIN_W = 4;
	localparam int WIN_MAPSZ = 64;

	localparam int SLV_COUNT = 4;
	localparam int GP0_COUNT = 16;
	localparam int GP1_COUNT = 5;

	// Interrupt sources in intctrl order
	localparam int INT_SRC_COUNT = 2;
	localparam int INT_SRC_GP0IO = 0;
	localparam int INT_SRC_GP1IO = 1;
	localparam int INT_IDX_W = 1;

	localparam int RST_CNTR_W = 4;

	localparam logic [7:0] DEV_ID_DEVTBL = 8'd7;
	localparam logic [7:0] DEV_ID_GPIO = 8'd6;
	localparam logic [7:0] DEV_ID_INTCTRL = 8'd3;

	// Register offsets inside a window
	localparam logic [WIN_W-1:0] GPIO_OFF_IN = 4'd0;
	localparam logic [WIN_W-1:0] GPIO_OFF_OUT = 4'd1;
	localparam logic [WIN_W-1:0] GPIO_OFF_IEN = 4'd2;
	localparam logic [WIN_W-1:0] INT_OFF_ACK = 4'd0;
	localparam logic [WIN_W-1:0] INT_OFF_MASK = 4'd1;
	localparam logic [WIN_W-1:0] DEVTBL_OFF_RST = 4'd15;

	// Software reset commands in bits 1..0 of the reset word
	localparam logic [1:0] RST_CMD_COLD = 2'b11;
	localparam logic [1:0] RST_CMD_WARM = 2'b10;
	localparam logic [1:0] RST_CMD_OFF = 2'b01;

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		WRITE = 2'b01,
		READ = 2'b10
	} pi1_op_e;

	typedef enum logic [1:0] {
		SLV_DEVTBL = 2'd0,
		SLV_GP0IO = 2'd1,
		SLV_GP1IO = 2'd2,
		SLV_INTCTRL = 2'd3
	} slv_idx_e;

	typedef struct packed {
		pi1_op_e op;
		logic [ADDR_W-1:0] addr;
		logic [ARCH_W-1:0] data;
		logic [SEL_W-1:0] sel;
	} pi1_req_t;

	typedef struct packed {
		logic [ARCH_W-1:0] data;
		logic rdy;
	} pi1_rsp_t;

	// Request as seen by a device, strobe is one cycle wide
	typedef struct packed {
		logic stb;
		logic we;
		logic [WIN_W-1:0] off;
		logic [ARCH_W-1:0] data;
		logic [SEL_W-1:0] sel;
	} dev_req_t;

endpackage

`default_nettype wire

//--- logic/rst_sequencer.sv
// Reset sequencer
`timescale 1ns/1ns
`default_nettype none

module rst_sequencer (
	 input  logic clk_2x_w
	,input  logic rst_p
	,input  logic warm_rst_i
	,input  logic off_i
	,output logic sys_rst_o
);
	import soc_pkg::*;

	logic [RST_CNTR_W-1:0] cntr_q;
	logic off_q;

	// Hold counter reloads on either reset source
	always_ff @(posedge clk_2x_w) begin
		if (rst_p || warm_rst_i)
			cntr_q <= '1;
		else if (cntr_q != '0)
			cntr_q <= cntr_q - RST_CNTR_W'(1);
	end

	// Power-off only leaves through the external reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			off_q <= 1'b0;
		else if (off_i)
			off_q <= 1'b1;
	end

	assign sys_rst_o = (cntr_q != '0) || off_q;

endmodule

`default_nettype wire

//--- logic/pi1_interconnect.sv
// PI1 bus interconnect
`timescale 1ns/1ns
`default_nettype none

module pi1_interconnect (
	 input  logic                             clk_2x_w
	,input  logic                             sys_rst_i
	,input  soc_pkg::pi1_req_t                pi1_req_i
	,output soc_pkg::pi1_rsp_t                pi1_rsp_o
	,output soc_pkg::dev_req_t                dev_req_o
	,output logic [soc_pkg::SLV_COUNT-1:0]    dev_sel_o
	,input  logic [soc_pkg::ARCH_W-1:0]       dev_rdata_i [soc_pkg::SLV_COUNT]
);
	import soc_pkg::*;

	pi1_req_t req_q;
	logic acc_q;
	logic busy_q;
	dev_req_t dev_q;
	logic [SLV_COUNT-1:0] sel_q;
	logic inv_q;
	slv_idx_e idx_q;
	pi1_rsp_t rsp_q;

	logic accept;
	logic [ADDR_W-WIN_W-1:0] win;
	logic win_ok;
	slv_idx_e win_idx;

	// A held request must not be taken twice while rdy is up
	assign accept = !busy_q && !rsp_q.rdy && (pi1_req_i.op != IDLE);

	// Window index sits above the word offset
	assign win = req_q.addr[ADDR_W-1:WIN_W];
	assign win_ok = (win < SLV_COUNT);
	assign win_idx = slv_idx_e'(win[1:0]);

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			acc_q <= 1'b0;
			busy_q <= 1'b0;
		end else begin
			acc_q <= accept;
			if (accept)
				busy_q <= 1'b1;
			else if (dev_q.stb)
				busy_q <= 1'b0;
		end
		if (accept)
			req_q <= pi1_req_i;
	end

	// Strobe stage, the select is empty for the invalid device
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			dev_q.stb <= 1'b0;
			sel_q <= '0;
		end else begin
			dev_q.stb <= acc_q;
			sel_q <= (acc_q && win_ok) ? (SLV_COUNT'(1) << win_idx) : '0;
		end
		if (acc_q) begin
			dev_q.we <= (req_q.op == WRITE);
			dev_q.off <= req_q.addr[WIN_W-1:0];
			dev_q.data <= req_q.data;
			dev_q.sel <= req_q.sel;
			inv_q <= !win_ok;
			idx_q <= win_idx;
		end
	end

	// Response stage
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i)
			rsp_q.rdy <= 1'b0;
		else
			rsp_q.rdy <= dev_q.stb;
		if (dev_q.stb)
			rsp_q.data <= inv_q ? '0 : dev_rdata_i[idx_q];
	end

	assign pi1_rsp_o = rsp_q;
	assign dev_req_o = dev_q;
	assign dev_sel_o = sel_q;

endmodule

`default_nettype wire

//--- logic/devtbl.sv
// Device table
`timescale 1ns/1ns
`default_nettype none

module devtbl (
	 input  logic                        clk_2x_w
	,input  logic                        sys_rst_i
	,input  soc_pkg::dev_req_t           dev_req_i
	,input  logic                        dev_sel_i
	,output logic [soc_pkg::ARCH_W-1:0]  rdata_o
	,output logic                        warm_rst_o
	,output logic                        off_o
);
	import soc_pkg::*;

	logic [7:0] ent_id;
	logic ent_intr;
	logic ent_ok;
	logic rst_wr;
	logic [1:0] rst_cmd;
	logic warm_q;
	logic off_q;

	// One entry per device slot
	always_comb begin
		ent_id = '0;
		ent_intr = 1'b0;
		case (dev_req_i.off)
			WIN_W'(SLV_DEVTBL): ent_id = DEV_ID_DEVTBL;
			WIN_W'(SLV_GP0IO), WIN_W'(SLV_GP1IO): begin
				ent_id = DEV_ID_GPIO;
				ent_intr = 1'b1;
			end
			WIN_W'(SLV_INTCTRL): ent_id = DEV_ID_INTCTRL;
			default: ent_id = '0;
		endcase
	end

	assign ent_ok = (dev_req_i.off < WIN_W'(SLV_COUNT));
	assign rdata_o = ent_ok ? {16'(WIN_MAPSZ), 7'd0, ent_intr, ent_id} : '0;

	assign rst_wr = dev_req_i.stb && dev_sel_i && dev_req_i.we && dev_req_i.sel[0] &&
		(dev_req_i.off == DEVTBL_OFF_RST);
	assign rst_cmd = dev_req_i.data[1:0];

	// Cold and warm both restart through the hold counter
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			warm_q <= 1'b0;
			off_q <= 1'b0;
		end else begin
			warm_q <= rst_wr && ((rst_cmd == RST_CMD_COLD) || (rst_cmd == RST_CMD_WARM));
			off_q <= rst_wr && (rst_cmd == RST_CMD_OFF);
		end
	end

	assign warm_rst_o = warm_q;
	assign off_o = off_q;

endmodule

`default_nettype wire

//--- logic/gpio.sv
// General-purpose I/O bank
`timescale 1ns/1ns
`default_nettype none

module gpio #(
	parameter int IO_COUNT = soc_pkg::GP0_COUNT
) (
	 input  logic                        clk_2x_w
	,input  logic                        sys_rst_i
	,input  soc_pkg::dev_req_t           dev_req_i
	,input  logic                        dev_sel_i
	,output logic [soc_pkg::ARCH_W-1:0]  rdata_o
	,output logic                        intrqst_o
	,input  logic                        intrdy_i
	,input  logic [IO_COUNT-1:0]         io_i
	,output logic [IO_COUNT-1:0]         io_o
);
	import soc_pkg::*;

	logic [IO_COUNT-1:0] sync1_q;
	logic [IO_COUNT-1:0] sync2_q;
	logic [IO_COUNT-1:0] prev_q;
	logic [IO_COUNT-1:0] out_q;
	logic ien_q;
	logic intrqst_q;
	logic wr;
	logic changed;

	assign wr = dev_req_i.stb && dev_sel_i && dev_req_i.we;
	assign changed = |(sync2_q ^ prev_q);

	// Two synchronizer stages, then one more for edge detection
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q <= '0;
		end else begin
			sync1_q <= io_i;
			sync2_q <= sync1_q;
			prev_q <= sync2_q;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			out_q <= '0;
			ien_q <= 1'b0;
		end else begin
			if (wr && (dev_req_i.off == GPIO_OFF_OUT)) begin
				for (int i = 0; i < IO_COUNT; i++)
					if (dev_req_i.sel[i/8])
						out_q[i] <= dev_req_i.data[i];
			end
			if (wr && (dev_req_i.off == GPIO_OFF_IEN) && dev_req_i.sel[0])
				ien_q <= dev_req_i.data[0];
		end
	end

	// A fresh change wins over a same-cycle acknowledge
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i)
			intrqst_q <= 1'b0;
		else if (ien_q && changed)
			intrqst_q <= 1'b1;
		else if (intrdy_i)
			intrqst_q <= 1'b0;
	end

	always_comb begin
		case (dev_req_i.off)
			GPIO_OFF_IN: rdata_o = ARCH_W'(sync2_q);
			GPIO_OFF_OUT: rdata_o = ARCH_W'(out_q);
			GPIO_OFF_IEN: rdata_o = ARCH_W'(ien_q);
			default: rdata_o = '0;
		endcase
	end

	assign intrqst_o = intrqst_q;
	assign io_o = out_q;

endmodule

`default_nettype wire

//--- intctrl/intctrl.sv
// Interrupt controller
`timescale 1ns/1ns
`default_nettype none

module intctrl (
	 input  logic                                clk_2x_w
	,input  logic                                sys_rst_i
	,input  soc_pkg::dev_req_t                   dev_req_i
	,input  logic                                dev_sel_i
	,output logic [soc_pkg::ARCH_W-1:0]          rdata_o
	,input  logic [soc_pkg::INT_SRC_COUNT-1:0]   intrqstsrc_i
	,output logic [soc_pkg::INT_SRC_COUNT-1:0]   intrdysrc_o
	,output logic                                intrqst_o
);
	import soc_pkg::*;

	logic [INT_SRC_COUNT-1:0] pend_q;
	logic [INT_SRC_COUNT-1:0] en_q;
	logic [INT_SRC_COUNT-1:0] active;
	logic [INT_SRC_COUNT-1:0] ack;
	logic wr;
	logic found;
	logic [INT_IDX_W-1:0] best;

	assign wr = dev_req_i.stb && dev_sel_i && dev_req_i.we && dev_req_i.sel[0];
	assign active = pend_q & en_q;

	// Scan from the top so the lowest index is left in best
	always_comb begin
		found = 1'b0;
		best = '0;
		for (int i = INT_SRC_COUNT - 1; i >= 0; i--) begin
			if (active[i]) begin
				found = 1'b1;
				best = INT_IDX_W'(i);
			end
		end
	end

	// Acknowledge write carries the source index
	always_comb begin
		for (int i = 0; i < INT_SRC_COUNT; i++)
			ack[i] = wr && (dev_req_i.off == INT_OFF_ACK) && (dev_req_i.data == ARCH_W'(i));
	end

	// Ack clears the pending bit in the same edge the source drops its request
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i)
			pend_q <= '0;
		else
			pend_q <= (pend_q | intrqstsrc_i) & ~ack;
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i)
			en_q <= '0;
		else if (wr && (dev_req_i.off == INT_OFF_MASK))
			en_q <= dev_req_i.data[INT_SRC_COUNT-1:0];
	end

	always_comb begin
		case (dev_req_i.off)
			INT_OFF_ACK: rdata_o = {found, {(ARCH_W - 1 - INT_IDX_W){1'b0}}, best};
			INT_OFF_MASK: rdata_o = ARCH_W'(en_q);
			default: rdata_o = '0;
		endcase
	end

	assign intrdysrc_o = ack;

	// Held low from the first cycle of a system reset
	assign intrqst_o = (|active) && !sys_rst_i;

endmodule

`default_nettype wire

//--- logic/soc_top.sv
// Peripheral SoC top level
`timescale 1ns/1ns
`default_nettype none

module soc_top (
	 input  logic                              clk_2x_w
	,input  logic                              rst_p
	,input  soc_pkg::pi1_req_t                 pi1_req_i
	,output soc_pkg::pi1_rsp_t                 pi1_rsp_o
	,input  logic [soc_pkg::GP0_COUNT-1:0]     gp0_i
	,output logic [soc_pkg::GP0_COUNT-1:0]     gp0_o
	,input  logic [soc_pkg::GP1_COUNT-1:0]     gp1_i
	,output logic                              intrqst_o
	,output logic                              sys_rst_o
);
	import soc_pkg::*;

	logic warm_rst;
	logic pwr_off;
	dev_req_t dev_req;
	logic [SLV_COUNT-1:0] dev_sel;
	logic [ARCH_W-1:0] dev_rdata [SLV_COUNT];
	logic [INT_SRC_COUNT-1:0] intrqstsrc;
	logic [INT_SRC_COUNT-1:0] intrdysrc;

	rst_sequencer rst_sequencer (
		 .clk_2x_w (clk_2x_w), .rst_p (rst_p)
		,.warm_rst_i (warm_rst), .off_i (pwr_off), .sys_rst_o (sys_rst_o)
	);

	pi1_interconnect pi1_interconnect (
		 .clk_2x_w (clk_2x_w), .sys_rst_i (sys_rst_o)
		,.pi1_req_i (pi1_req_i), .pi1_rsp_o (pi1_rsp_o)
		,.dev_req_o (dev_req), .dev_sel_o (dev_sel), .dev_rdata_i (dev_rdata)
	);

	devtbl devtbl (
		 .clk_2x_w (clk_2x_w), .sys_rst_i (sys_rst_o)
		,.dev_req_i (dev_req), .dev_sel_i (dev_sel[SLV_DEVTBL])
		,.rdata_o (dev_rdata[SLV_DEVTBL]), .warm_rst_o (warm_rst), .off_o (pwr_off)
	);

	gpio #(.IO_COUNT (GP0_COUNT)) gpio_switches_leds (
		 .clk_2x_w (clk_2x_w), .sys_rst_i (sys_rst_o)
		,.dev_req_i (dev_req), .dev_sel_i (dev_sel[SLV_GP0IO]), .rdata_o (dev_rdata[SLV_GP0IO])
		,.intrqst_o (intrqstsrc[INT_SRC_GP0IO]), .intrdy_i (intrdysrc[INT_SRC_GP0IO])
		,.io_i (gp0_i), .io_o (gp0_o)
	);

	// Buttons have no outputs
	gpio #(.IO_COUNT (GP1_COUNT)) gpio_buttons (
		 .clk_2x_w (clk_2x_w), .sys_rst_i (sys_rst_o)
		,.dev_req_i (dev_req), .dev_sel_i (dev_sel[SLV_GP1IO]), .rdata_o (dev_rdata[SLV_GP1IO])
		,.intrqst_o (intrqstsrc[INT_SRC_GP1IO]), .intrdy_i (intrdysrc[INT_SRC_GP1IO])
		,.io_i (gp1_i), .io_o ()
	);

	intctrl intctrl (
		 .clk_2x_w (clk_2x_w), .sys_rst_i (sys_rst_o)
		,.dev_req_i (dev_req), .dev_sel_i (dev_sel[SLV_INTCTRL])
		,.rdata_o (dev_rdata[SLV_INTCTRL])
		,.intrqstsrc_i (intrqstsrc), .intrdysrc_o (intrdysrc), .intrqst_o (intrqst_o)
	);

endmodule

`default_nettype wire

//--- tests/soc_properties.sv
// Top-level port checks
`timescale 1ns/1ns
`default_nettype none

module soc_properties (
	 input  logic              clk_2x_w
	,input  logic              rst_p
	,input  soc_pkg::pi1_rsp_t rsp_i
	,input  logic              intrqst_i
	,input  logic              sys_rst_i
);
	int fail_count = 0;

	// One rdy pulse per accepted request
	rdy_single: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		rsp_i.rdy |=> !rsp_i.rdy)
		else begin
			fail_count++;
			$error("rdy stayed high for a second cycle");
		end

	rdy_quiet_in_reset: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		sys_rst_i |-> !rsp_i.rdy)
		else begin
			fail_count++;
			$error("rdy high while sys_rst_o is high");
		end

	// Pending state is cleared by the system reset
	irq_quiet_in_reset: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		sys_rst_i |-> !intrqst_i)
		else begin
			fail_count++;
			$error("intrqst_o high while sys_rst_o is high");
		end

endmodule

`default_nettype wire

//--- tests/tb_soc.sv
// SoC peripheral testbench
`timescale 1ns/1ns
`default_nettype none

module tb_soc;
	import soc_pkg::*;

	localparam int HOLD_EDGES = 15;
	// One edge to accept, two more until rdy
	localparam int RSP_EDGES = 3;
	// Three edges through gpio, one more through intctrl
	localparam int IRQ_EDGES = 4;
	localparam int OFF_EDGES = 40;

	logic clk_2x_w;
	logic rst_p;
	pi1_req_t pi1_req;
	pi1_rsp_t pi1_rsp;
	logic [GP0_COUNT-1:0] gp0_in;
	logic [GP0_COUNT-1:0] gp0_out;
	logic [GP1_COUNT-1:0] gp1_in;
	logic intrqst;
	logic sys_rst;

	int cycles = 0;
	int cycle_limit = 100;
	int cmd_count = 0;

	soc_top i_soc_top (
		 .clk_2x_w (clk_2x_w), .rst_p (rst_p)
		,.pi1_req_i (pi1_req), .pi1_rsp_o (pi1_rsp)
		,.gp0_i (gp0_in), .gp0_o (gp0_out), .gp1_i (gp1_in)
		,.intrqst_o (intrqst), .sys_rst_o (sys_rst)
	);

	bind soc_top soc_properties props (
		 .clk_2x_w (clk_2x_w), .rst_p (rst_p), .rsp_i (pi1_rsp_o)
		,.intrqst_i (intrqst_o), .sys_rst_i (sys_rst_o)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever #2 clk_2x_w = ~clk_2x_w;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	always @(posedge clk_2x_w) begin
		cycles++;
		if (cycles >= cycle_limit)
			stop_on_error($sformatf("Timeout, run did not end within %0d cycles", cycle_limit));
	end

	// The bound checker counts its own assertion failures
	always @(negedge clk_2x_w) begin
		if (i_soc_top.props.fail_count != 0)
			stop_on_error("An assertion on the top-level ports failed");
	end

	task automatic check_rsp(input pi1_rsp_t actual, input pi1_rsp_t expected);
		if (actual.rdy !== expected.rdy)
			stop_on_error($sformatf("[ERROR] t=%0t pi1_rsp_o.rdy: got %b expected %b",
				$time, actual.rdy, expected.rdy));
		if (actual.data !== expected.data)
			stop_on_error($sformatf("[ERROR] t=%0t pi1_rsp_o.data: got %h expected %h",
				$time, actual.data, expected.data));
	endtask

	task automatic check_gpio(input logic [GP0_COUNT-1:0] actual,
		input logic [GP0_COUNT-1:0] expected);
		if (actual !== expected)
			stop_on_error($sformatf("[ERROR] t=%0t gp0_o: got %h expected %h",
				$time, actual, expected));
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			stop_on_error($sformatf("[ERROR] t=%0t %s: got %b expected %b",
				$time, name, actual, expected));
	endtask

	task automatic check_edges(input string name, input int actual, input int expected);
		if (actual != expected)
			stop_on_error($sformatf("[ERROR] t=%0t %s: got %0d edges expected %0d",
				$time, name, actual, expected));
	endtask

	task automatic need_fields(input int got, input int want);
		if (got != want)
			stop_on_error("A line of the golden file has missing fields");
	endtask

	// Ends on the edge after the expected rdy cycle, with the bus back to idle
	task automatic bus_access(input pi1_op_e op, input logic [ADDR_W-1:0] addr,
		input logic [ARCH_W-1:0] data, input logic [SEL_W-1:0] sel, output pi1_rsp_t rsp);
		int edges;
		edges = 0;
		rsp = '0;
		@(posedge clk_2x_w);
		pi1_req <= '{op, addr, data, sel};
		while (!rsp.rdy && edges < RSP_EDGES) begin
			@(posedge clk_2x_w);
			edges++;
			@(negedge clk_2x_w);
			rsp = pi1_rsp;
		end
		check_edges("pi1_rsp_o.rdy latency", edges, RSP_EDGES);
		@(posedge clk_2x_w);
		pi1_req <= '{IDLE, '0, '0, '0};
	endtask

	// Called on the edge that last loads the hold counter
	task automatic measure_hold();
		int edges;
		edges = 0;
		@(negedge clk_2x_w);
		check_bit("sys_rst_o", sys_rst, 1'b1);
		while (sys_rst) begin
			check_bit("pi1_rsp_o.rdy", pi1_rsp.rdy, 1'b0);
			@(posedge clk_2x_w);
			edges++;
			// A read offered during the hold must not be accepted
			if (edges == 1)
				pi1_req <= '{READ, '0, '0, '1};
			else if (edges == 3)
				pi1_req <= '{IDLE, '0, '0, '0};
			@(negedge clk_2x_w);
		end
		check_edges("sys_rst_o hold", edges, HOLD_EDGES);
	endtask

	task automatic release_reset();
		repeat (3) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		measure_hold();
	endtask

	task automatic wait_irq(input logic level);
		int edges;
		edges = 0;
		@(negedge clk_2x_w);
		while (intrqst !== level) begin
			if (edges >= IRQ_EDGES)
				stop_on_error($sformatf("intrqst_o did not reach %b within %0d edges",
					level, IRQ_EDGES));
			@(posedge clk_2x_w);
			edges++;
			@(negedge clk_2x_w);
		end
	endtask

	// Reset word bits 1..0: 11 cold, 10 warm, 01 power-off, 00 nothing
	task automatic soft_reset(input logic [ARCH_W-1:0] word);
		pi1_rsp_t rsp;
		bus_access(WRITE, ADDR_W'(15), word, SEL_W'(1), rsp);
		check_bit("pi1_rsp_o.rdy", rsp.rdy, 1'b1);
		case (word[1:0])
			2'b11, 2'b10: begin
				measure_hold();
				check_gpio(gp0_out, '0);
			end
			2'b01: begin
				repeat (OFF_EDGES) begin
					@(negedge clk_2x_w);
					check_bit("sys_rst_o", sys_rst, 1'b1);
				end
				@(posedge clk_2x_w);
				rst_p <= 1'b1;
				release_reset();
				check_gpio(gp0_out, '0);
			end
			default: begin
				repeat (OFF_EDGES) begin
					@(negedge clk_2x_w);
					check_bit("sys_rst_o", sys_rst, 1'b0);
				end
			end
		endcase
	endtask

	initial begin
		int fd;
		int code;
		int line_count;
		logic [7:0] cmd;
		logic [8*128-1:0] text;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		pi1_rsp_t rsp;
		pi1_rsp_t exp_rsp;

		rst_p = 1'b1;
		pi1_req = '{IDLE, '0, '0, '0};
		gp0_in = '0;
		gp1_in = '0;
		line_count = 0;

		// Size the timeout from the length of the golden file
		fd = $fopen("tests/soc_golden.txt", "r");
		if (fd == 0)
			stop_on_error("Cannot open tests/soc_golden.txt");
		while (!$feof(fd)) begin
			code = $fgets(text, fd);
			if (code > 0)
				line_count++;
		end
		$fclose(fd);
		cycle_limit = line_count * 40 + 100;

		release_reset();

		fd = $fopen("tests/soc_golden.txt", "r");
		code = $fscanf(fd, "%s", cmd);
		while (code == 1) begin
			if (cmd == "#") begin
				code = $fgets(text, fd);
			end else begin
				cmd_count++;
				case (cmd)
					"W": begin
						need_fields($fscanf(fd, "%h %h %h", a0, a1, a2), 3);
						bus_access(WRITE, ADDR_W'(a0), a1, SEL_W'(a2), rsp);
						check_bit("pi1_rsp_o.rdy", rsp.rdy, 1'b1);
					end
					"R": begin
						need_fields($fscanf(fd, "%h %h", a0, a1), 2);
						bus_access(READ, ADDR_W'(a0), '0, '1, rsp);
						exp_rsp.data = a1;
						exp_rsp.rdy = 1'b1;
						check_rsp(rsp, exp_rsp);
					end
					"P": begin
						need_fields($fscanf(fd, "%h %h", a0, a1), 2);
						@(posedge clk_2x_w);
						gp0_in <= GP0_COUNT'(a0);
						gp1_in <= GP1_COUNT'(a1);
					end
					"L": begin
						need_fields($fscanf(fd, "%h", a0), 1);
						@(negedge clk_2x_w);
						check_gpio(gp0_out, GP0_COUNT'(a0));
					end
					"I": begin
						need_fields($fscanf(fd, "%h", a0), 1);
						wait_irq(a0[0]);
					end
					"S": begin
						need_fields($fscanf(fd, "%h", a0), 1);
						soft_reset(a0);
					end
					default: stop_on_error($sformatf("Unknown command %s in golden file", cmd));
				endcase
			end
			code = $fscanf(fd, "%s", cmd);
		end
		$fclose(fd);

		if (cmd_count > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("No commands were run from the golden file");
			$display("RESULT: FAIL");
			$fatal(1, "Empty stimulus");
		end
	end

endmodule

`default_nettype wire

//--- tests/soc_golden.txt
# W addr data sel | R addr expected | P gp0_i gp1_i | L gp0_o expected
# I intrqst_o level | S reset word | word addresses, all values in hex
P 0000a5c3 00000015
R 00000000 00400007
R 00000001 00400106
R 00000002 00400106
R 00000003 00400003
R 00000004 00000000
W 00000011 12345678 f
L 5678
W 00000011 ffffab00 2
L ab78
R 00000011 0000ab78
R 00000010 0000a5c3
R 00000020 00000015
R 00000050 00000000
W 00000050 deadbeef f
R 00000050 00000000
R 00000011 0000ab78
R 00000000 00400007
W 00000031 00000003 1
W 00000012 00000001 1
W 00000022 00000001 1
P 0000a5c3 00000014
I 1
R 00000030 80000001
W 00000030 00000001 1
I 0
R 00000030 00000000
S 00000003
L 0000
R 00000011 00000000
W 00000011 0000ffff 3
L ffff
S 00000002
L 0000
S 00000001
R 00000000 00400007
R 00000011 00000000

//--- flist.f
common/soc_pkg.sv
logic/rst_sequencer.sv
logic/pi1_interconnect.sv
logic/devtbl.sv
logic/gpio.sv
intctrl/intctrl.sv
logic/soc_top.sv
tests/soc_properties.sv
tests/tb_soc.sv

//--- Makefile
# Verilator flow for the peripheral SoC

TOP = tb_soc

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module soc_top

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim_soc
	./obj_dir/sim_soc +verilator+error+limit+10 > sim.log 2>&1 || true
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
